//--- cache_top.f
+incdir+include
hdl/cache_bus_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/cache_tag_store.sv
hdl/cache_line_ram.sv
hdl/cache_refill.sv
hdl/cache_controller.sv
hdl/cache_top.sv
verification/cache_tb.sv

//--- hdl/cache_bus_pkg.sv
package cache_bus_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    localparam int word_bits = 32;
    localparam int addr_bits = 32;
    localparam int byte_bits = 8;

    // one select bit per byte lane
    localparam int bytes_per_word = word_bits / byte_bits;

    // low address bits that pick a byte inside a word
    localparam int byte_offset_bits = $clog2(bytes_per_word);

    ////////////////////
    // bus types
    ////////////////////

    // data word on the cpu and the memory bus
    typedef logic [word_bits-1:0] word_t;

    // byte address, always word aligned on both buses
    typedef logic [addr_bits-1:0] addr_t;

    // byte select, bit n enables lane n
    typedef logic [bytes_per_word-1:0] sel_t;

endpackage

//--- hdl/cache_controller.sv
`timescale 1ns/1ps

module cache_controller #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 3
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 cpu_cyc,
    input  logic                 cpu_stb,
    input  logic                 cpu_we,
    input  cache_bus_pkg::addr_t cpu_adr,
    input  cache_bus_pkg::sel_t  cpu_sel,
    input  cache_bus_pkg::word_t cpu_dat_w,
    output logic                 cpu_ack,
    output cache_bus_pkg::addr_t lookup_adr,
    input  logic                 hit,
    output cache_bus_pkg::addr_t rd_adr,
    output logic                 cpu_wr_en,
    output logic                 refill_start,
    input  logic                 refill_done,
    output logic                 fill_commit
);

    localparam int index_lsb = cache_bus_pkg::byte_offset_bits + offset_bits;
    localparam int tag_lsb   = index_lsb + index_bits;
    localparam int tag_bits  = cache_bus_pkg::addr_bits - tag_lsb;

    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [index_bits-1:0] index_t;

    cache_ctrl_pkg::ctrl_state_t state;
    cache_bus_pkg::addr_t        req_adr;
    cache_bus_pkg::addr_t        line_base;
    tag_t                        req_tag;
    index_t                      req_index;
    logic                        req_valid;

    // ack is still high in the cycle the master samples it, so ignore that cycle
    assign req_valid = cpu_cyc && cpu_stb && !cpu_ack;

    assign req_tag   = req_adr[cache_bus_pkg::addr_bits-1:tag_lsb];
    assign req_index = req_adr[tag_lsb-1:index_lsb];
    assign line_base = {req_tag, req_index, {index_lsb{1'b0}}};

    ////////////////////
    // request FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state        <= cache_ctrl_pkg::ctrl_idle;
            cpu_ack      <= 1'b0;
            refill_start <= 1'b0;
        end else begin
            cpu_ack      <= 1'b0;
            refill_start <= 1'b0;
            case (state)
                cache_ctrl_pkg::ctrl_idle: begin
                    if (req_valid) begin
                        state <= cache_ctrl_pkg::ctrl_lookup;
                    end
                end
                cache_ctrl_pkg::ctrl_lookup: begin
                    if (hit) begin
                        state <= cache_ctrl_pkg::ctrl_respond;
                    end else begin
                        refill_start <= 1'b1;
                        state        <= cache_ctrl_pkg::ctrl_refill_wait;
                    end
                end
                cache_ctrl_pkg::ctrl_respond: begin
                    cpu_ack <= 1'b1;
                    state   <= cache_ctrl_pkg::ctrl_idle;
                end
                cache_ctrl_pkg::ctrl_refill_wait: begin
                    // tag is committed in this cycle, so the next lookup hits
                    if (refill_done) begin
                        state <= cache_ctrl_pkg::ctrl_lookup;
                    end
                end
                default: begin
                    state <= cache_ctrl_pkg::ctrl_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == cache_ctrl_pkg::ctrl_idle) && req_valid) begin
            req_adr <= cpu_adr;
        end
    end

    ////////////////////
    // datapath control
    ////////////////////

    // idle looks up the live bus address so a hit needs no extra cycle
    always_comb begin
        case (state)
            cache_ctrl_pkg::ctrl_idle:        lookup_adr = cpu_adr;
            cache_ctrl_pkg::ctrl_refill_wait: lookup_adr = line_base;
            default:                          lookup_adr = req_adr;
        endcase
    end

    assign rd_adr      = req_adr;
    assign fill_commit = (state == cache_ctrl_pkg::ctrl_refill_wait) && refill_done;

    // cpu_sel and cpu_dat_w go to the line memory from the top level
    assign cpu_wr_en = (state == cache_ctrl_pkg::ctrl_respond) && cpu_we
                       && (cpu_sel != '0);

    cpu_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!reset_n)
        cpu_ack |-> cpu_cyc && cpu_stb
    );

endmodule

//--- hdl/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    // cpu request sequencing
    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_lookup,
        ctrl_respond,
        ctrl_refill_wait
    } ctrl_state_t;

    // line fetch from memory, one word per bus cycle
    typedef enum logic [1:0] {
        fill_idle,
        fill_fetch,
        fill_done
    } refill_state_t;

endpackage

//--- hdl/cache_line_ram.sv
`timescale 1ns/1ps

module cache_line_ram #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 3
) (
    input  logic                 clk,
    input  cache_bus_pkg::addr_t rd_adr,
    output cache_bus_pkg::word_t rd_dat,
    input  logic                 cpu_wr_en,
    input  cache_bus_pkg::addr_t cpu_wr_adr,
    input  cache_bus_pkg::sel_t  cpu_wr_sel,
    input  cache_bus_pkg::word_t cpu_wr_dat,
    input  logic                 fill_wr_en,
    input  cache_bus_pkg::addr_t fill_wr_adr,
    input  cache_bus_pkg::word_t fill_wr_dat
);

    localparam int word_lsb   = cache_bus_pkg::byte_offset_bits;
    localparam int slot_bits  = index_bits + offset_bits;
    localparam int depth      = 2 ** slot_bits;
    localparam int lane_bits  = cache_bus_pkg::byte_bits;

    // slot is line index and word offset side by side
    typedef logic [slot_bits-1:0] slot_t;

    cache_bus_pkg::word_t mem [depth];

    slot_t rd_slot;
    slot_t cpu_slot;
    slot_t fill_slot;

    assign rd_slot   = rd_adr[word_lsb +: slot_bits];
    assign cpu_slot  = cpu_wr_adr[word_lsb +: slot_bits];
    assign fill_slot = fill_wr_adr[word_lsb +: slot_bits];

    always_ff @(posedge clk) begin
        // refill writes whole words
        if (fill_wr_en) begin
            mem[fill_slot] <= fill_wr_dat;
        end
        // cpu writes only the selected lanes
        if (cpu_wr_en) begin
            for (int lane = 0; lane < cache_bus_pkg::bytes_per_word; lane++) begin
                if (cpu_wr_sel[lane]) begin
                    mem[cpu_slot][lane*lane_bits +: lane_bits] <=
                        cpu_wr_dat[lane*lane_bits +: lane_bits];
                end
            end
        end
        // read returns the old word on a same-cycle write
        rd_dat <= mem[rd_slot];
    end

    // the controller holds the cpu off while a refill runs
    one_write_port: assert property (@(posedge clk) !(cpu_wr_en && fill_wr_en));

endmodule

//--- hdl/cache_refill.sv
`timescale 1ns/1ps

module cache_refill #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 3
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 refill_start,
    input  cache_bus_pkg::addr_t line_adr,
    output logic                 refill_done,
    output logic                 mem_cyc,
    output logic                 mem_stb,
    output cache_bus_pkg::addr_t mem_adr,
    input  cache_bus_pkg::word_t mem_dat_r,
    input  logic                 mem_ack,
    output logic                 fill_wr_en,
    output cache_bus_pkg::addr_t fill_wr_adr,
    output cache_bus_pkg::word_t fill_wr_dat
);

    localparam int word_lsb   = cache_bus_pkg::byte_offset_bits;
    localparam int index_lsb  = word_lsb + offset_bits;
    localparam int tag_lsb    = index_lsb + index_bits;
    localparam int tag_bits   = cache_bus_pkg::addr_bits - tag_lsb;
    localparam int line_words = 2 ** offset_bits;

    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [offset_bits-1:0] word_count_t;

    cache_ctrl_pkg::refill_state_t state;
    word_count_t                   word_cnt;
    tag_t                          line_tag;
    index_t                        line_index;
    logic                          last_word;

    assign last_word = (word_cnt == word_count_t'(line_words - 1));

    ////////////////////
    // fetch sequencing
    ////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= cache_ctrl_pkg::fill_idle;
            word_cnt <= '0;
        end else begin
            case (state)
                cache_ctrl_pkg::fill_idle: begin
                    if (refill_start) begin
                        state    <= cache_ctrl_pkg::fill_fetch;
                        word_cnt <= '0;
                    end
                end
                cache_ctrl_pkg::fill_fetch: begin
                    // next word only after the memory accepted this one
                    if (mem_ack) begin
                        if (last_word) begin
                            state <= cache_ctrl_pkg::fill_done;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= cache_ctrl_pkg::fill_idle;
                end
            endcase
        end
    end

    // line under refill, held for the whole fetch
    always_ff @(posedge clk) begin
        if ((state == cache_ctrl_pkg::fill_idle) && refill_start) begin
            line_tag   <= line_adr[cache_bus_pkg::addr_bits-1:tag_lsb];
            line_index <= line_adr[tag_lsb-1:index_lsb];
        end
    end

    ////////////////////
    // bus and fill port
    ////////////////////

    assign mem_cyc = (state == cache_ctrl_pkg::fill_fetch);
    assign mem_stb = (state == cache_ctrl_pkg::fill_fetch);
    assign mem_adr = {line_tag, line_index, word_cnt, {word_lsb{1'b0}}};

    assign refill_done = (state == cache_ctrl_pkg::fill_done);

    // each acked word goes straight into the line memory
    assign fill_wr_en  = mem_stb && mem_ack;
    assign fill_wr_adr = mem_adr;
    assign fill_wr_dat = mem_dat_r;

    mem_adr_held: assert property (
        @(posedge clk) disable iff (!reset_n)
        mem_stb && !mem_ack |=> $stable(mem_adr)
    );

endmodule

//--- hdl/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 3
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  cache_bus_pkg::addr_t lookup_adr,
    output logic                 hit,
    input  cache_bus_pkg::addr_t fill_adr,
    input  logic                 fill_commit
);

    localparam int index_lsb = cache_bus_pkg::byte_offset_bits + offset_bits;
    localparam int tag_lsb   = index_lsb + index_bits;
    localparam int tag_bits  = cache_bus_pkg::addr_bits - tag_lsb;
    localparam int lines     = 2 ** index_bits;

    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [index_bits-1:0] index_t;

    tag_t             tag_mem [lines];
    logic [lines-1:0] valid;

    index_t look_index_q;
    tag_t   look_tag_q;
    index_t fill_index;
    tag_t   fill_tag;

    assign fill_index = fill_adr[tag_lsb-1:index_lsb];
    assign fill_tag   = fill_adr[cache_bus_pkg::addr_bits-1:tag_lsb];

    // lookup address is sampled every cycle, result is valid one cycle later
    always_ff @(posedge clk) begin
        look_index_q <= lookup_adr[tag_lsb-1:index_lsb];
        look_tag_q   <= lookup_adr[cache_bus_pkg::addr_bits-1:tag_lsb];
    end

    always_ff @(posedge clk) begin
        if (fill_commit) begin
            tag_mem[fill_index] <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid <= '0;
        end else if (fill_commit) begin
            valid[fill_index] <= 1'b1;
        end
    end

    assign hit = valid[look_index_q] && (tag_mem[look_index_q] == look_tag_q);

    ////////////////////
    // checks
    ////////////////////

    // a line being committed was a miss, so it cannot report a hit meanwhile
    no_hit_on_commit: assert property (
        @(posedge clk) disable iff (!reset_n)
        fill_commit && (fill_index == look_index_q) |-> !hit
    );

endmodule

//--- hdl/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 3
) (
    input  logic                 clk,
    input  logic                 reset_n,
    // cpu bus, Wishbone classic slave
    input  logic                 cpu_cyc,
    input  logic                 cpu_stb,
    input  logic                 cpu_we,
    input  cache_bus_pkg::addr_t cpu_adr,
    input  cache_bus_pkg::sel_t  cpu_sel,
    input  cache_bus_pkg::word_t cpu_dat_w,
    output cache_bus_pkg::word_t cpu_dat_r,
    output logic                 cpu_ack,
    // memory bus, Wishbone classic master, reads only
    output logic                 mem_cyc,
    output logic                 mem_stb,
    output cache_bus_pkg::addr_t mem_adr,
    input  cache_bus_pkg::word_t mem_dat_r,
    input  logic                 mem_ack
);

    cache_bus_pkg::addr_t lookup_adr;
    cache_bus_pkg::addr_t rd_adr;
    cache_bus_pkg::addr_t fill_wr_adr;
    cache_bus_pkg::word_t fill_wr_dat;
    logic                 hit;
    logic                 cpu_wr_en;
    logic                 refill_start;
    logic                 refill_done;
    logic                 fill_commit;
    logic                 fill_wr_en;

    cache_controller #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_cache_controller (
        .clk          (clk),
        .reset_n      (reset_n),
        .cpu_cyc      (cpu_cyc),
        .cpu_stb      (cpu_stb),
        .cpu_we       (cpu_we),
        .cpu_adr      (cpu_adr),
        .cpu_sel      (cpu_sel),
        .cpu_dat_w    (cpu_dat_w),
        .cpu_ack      (cpu_ack),
        .lookup_adr   (lookup_adr),
        .hit          (hit),
        .rd_adr       (rd_adr),
        .cpu_wr_en    (cpu_wr_en),
        .refill_start (refill_start),
        .refill_done  (refill_done),
        .fill_commit  (fill_commit)
    );

    // lookup_adr carries the line base while a refill is pending
    cache_tag_store #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_cache_tag_store (
        .clk         (clk),
        .reset_n     (reset_n),
        .lookup_adr  (lookup_adr),
        .hit         (hit),
        .fill_adr    (lookup_adr),
        .fill_commit (fill_commit)
    );

    cache_line_ram #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_cache_line_ram (
        .clk         (clk),
        .rd_adr      (rd_adr),
        .rd_dat      (cpu_dat_r),
        .cpu_wr_en   (cpu_wr_en),
        .cpu_wr_adr  (cpu_adr),
        .cpu_wr_sel  (cpu_sel),
        .cpu_wr_dat  (cpu_dat_w),
        .fill_wr_en  (fill_wr_en),
        .fill_wr_adr (fill_wr_adr),
        .fill_wr_dat (fill_wr_dat)
    );

    cache_refill #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_cache_refill (
        .clk          (clk),
        .reset_n      (reset_n),
        .refill_start (refill_start),
        .line_adr     (lookup_adr),
        .refill_done  (refill_done),
        .mem_cyc      (mem_cyc),
        .mem_stb      (mem_stb),
        .mem_adr      (mem_adr),
        .mem_dat_r    (mem_dat_r),
        .mem_ack      (mem_ack),
        .fill_wr_en   (fill_wr_en),
        .fill_wr_adr  (fill_wr_adr),
        .fill_wr_dat  (fill_wr_dat)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the cache testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module cache_tb \
    --Mdir "$build_dir" \
    -o cache_tb_sim \
    -f cache_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/cache_tb_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the run counts as good only if the testbench printed its pass line
if grep -qx "Regression passed" "$log_file"; then
    exit 0
fi
echo "pass line not found in $log_file"
exit 1

//--- include/cache_tb_tests.svh
`ifndef CACHE_TB_TESTS_SVH
`define CACHE_TB_TESTS_SVH

// line_c shares the index of line_a with a different tag
localparam cache_bus_pkg::addr_t line_a = 32'h0000_1040;
localparam cache_bus_pkg::addr_t line_b = 32'h0000_2080;
localparam cache_bus_pkg::addr_t line_c = 32'h0000_1240;
localparam int hit_latency = 2;

function automatic cache_bus_pkg::word_t merge_lanes(input cache_bus_pkg::word_t old_word,
                                                     input cache_bus_pkg::word_t new_word,
                                                     input cache_bus_pkg::sel_t sel);
    cache_bus_pkg::word_t merged;
    merged = old_word;
    for (int lane = 0; lane < lanes; lane++) begin
        if (sel[lane]) begin
            merged[lane*8 +: 8] = new_word[lane*8 +: 8];
        end
    end
    return merged;
endfunction

// a refill reads its line word by word from the first word upward
task automatic expect_line_fetch(input cache_bus_pkg::addr_t line_base, input int first_read);
    for (int w = 0; w < line_words; w++) begin
        check_adr("mem_adr", read_log[first_read + w],
                  line_base + cache_bus_pkg::addr_t'(4 * w));
    end
endtask

// one Wishbone classic cycle, latency counts edges after the request edge
task automatic cpu_access(input logic we, input cache_bus_pkg::addr_t adr,
                          input cache_bus_pkg::sel_t sel, input cache_bus_pkg::word_t wdat,
                          output cache_bus_pkg::word_t rdat, output int latency);
    int edges;
    edges = 0;
    @(negedge clk);
    cpu_cyc   = 1'b1;
    cpu_stb   = 1'b1;
    cpu_we    = we;
    cpu_adr   = adr;
    cpu_sel   = sel;
    cpu_dat_w = wdat;
    do begin
        @(posedge clk);
        edges++;
        @(negedge clk);
    end while (!cpu_ack);
    rdat    = cpu_dat_r;
    latency = edges - 1;
    // ack is taken on the next rising edge, the cycle ends after it
    @(posedge clk);
    @(negedge clk);
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we  = 1'b0;
endtask

////////////////////
// directed tests
////////////////////

task automatic cold_read_refills();
    cache_bus_pkg::word_t rdat;
    int                   lat;
    int                   reads_before;
    reads_before = mem_reads;
    cpu_access(1'b0, line_a + 32'h0C, 4'hF, '0, rdat, lat);
    check_word("cpu_dat_r", rdat, model_word(line_a + 32'h0C));
    check_count("memory read count", mem_reads - reads_before, line_words);
    expect_line_fetch(line_a, reads_before);
endtask

task automatic filled_line_hits();
    cache_bus_pkg::word_t rdat;
    cache_bus_pkg::addr_t adr;
    int                   lat;
    int                   reads_before;
    reads_before = mem_reads;
    for (int w = 0; w < line_words; w++) begin
        adr = line_a + cache_bus_pkg::addr_t'(4 * w);
        cpu_access(1'b0, adr, 4'hF, '0, rdat, lat);
        check_word("cpu_dat_r", rdat, model_word(adr));
        check_count("cpu_ack latency", lat, hit_latency);
    end
    check_count("memory read count", mem_reads - reads_before, 0);
endtask

task automatic write_hit_merges();
    cache_bus_pkg::word_t rdat;
    int                   lat;
    int                   reads_before;
    reads_before = mem_reads;
    cpu_access(1'b1, line_a + 32'h08, 4'b0101, 32'h1122_3344, rdat, lat);
    check_count("cpu_ack latency", lat, hit_latency);
    cpu_access(1'b0, line_a + 32'h08, 4'hF, '0, rdat, lat);
    check_word("cpu_dat_r", rdat,
               merge_lanes(model_word(line_a + 32'h08), 32'h1122_3344, 4'b0101));
    check_count("memory read count", mem_reads - reads_before, 0);
endtask

task automatic write_miss_allocates();
    cache_bus_pkg::word_t rdat;
    int                   lat;
    int                   reads_before;
    reads_before = mem_reads;
    cpu_access(1'b1, line_b + 32'h14, 4'b1100, 32'hDEAD_BEEF, rdat, lat);
    check_count("memory read count", mem_reads - reads_before, line_words);
    expect_line_fetch(line_b, reads_before);
    cpu_access(1'b0, line_b + 32'h14, 4'hF, '0, rdat, lat);
    check_word("cpu_dat_r", rdat,
               merge_lanes(model_word(line_b + 32'h14), 32'hDEAD_BEEF, 4'b1100));
    check_count("memory read count", mem_reads - reads_before, line_words);
endtask

task automatic conflict_refetches();
    cache_bus_pkg::word_t rdat;
    int                   lat;
    int                   reads_before;
    reads_before = mem_reads;
    cpu_access(1'b0, line_c + 32'h08, 4'hF, '0, rdat, lat);
    check_word("cpu_dat_r", rdat, model_word(line_c + 32'h08));
    check_count("memory read count", mem_reads - reads_before, line_words);
    expect_line_fetch(line_c, reads_before);
    // the merged word was never written back, memory still holds the plain word
    cpu_access(1'b0, line_a + 32'h08, 4'hF, '0, rdat, lat);
    check_word("cpu_dat_r", rdat, model_word(line_a + 32'h08));
    check_count("memory read count", mem_reads - reads_before, 2 * line_words);
    expect_line_fetch(line_a, reads_before + line_words);
endtask

task automatic reset_clears_valid();
    cache_bus_pkg::word_t rdat;
    int                   lat;
    int                   reads_before;
    apply_reset();
    reads_before = mem_reads;
    cpu_access(1'b0, line_b + 32'h14, 4'hF, '0, rdat, lat);
    check_word("cpu_dat_r", rdat, model_word(line_b + 32'h14));
    check_count("memory read count", mem_reads - reads_before, line_words);
    expect_line_fetch(line_b, reads_before);
endtask

task automatic run_directed_tests();
    $display("cold read");
    cold_read_refills();
    $display("hits on the filled line");
    filled_line_hits();
    $display("write hit");
    write_hit_merges();
    $display("write miss");
    write_miss_allocates();
    $display("index conflict");
    conflict_refetches();
    $display("second reset");
    reset_clears_valid();
endtask

`endif

//--- verification/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    // geometry and memory model, kept apart from the RTL defaults
    localparam int index_bits    = 4;
    localparam int offset_bits   = 3;
    localparam int line_words    = 2 ** offset_bits;
    localparam int lanes         = 4;
    localparam int reset_cycles  = 16;
    localparam int max_ack_delay = 3;
    localparam int rand_seed     = 98047;
    localparam cache_bus_pkg::word_t model_xor = 32'hA5A5_0000;

    // a refill costs up to delay plus ack per word, plus the lookup and respond cycles
    localparam int worst_refill = line_words * (max_ack_delay + 2) + 8;
    localparam int test_count   = 6;
    localparam int max_cycles   = test_count * 2 * worst_refill + 2 * reset_cycles + 400;

    logic                 clk = 1'b0;
    logic                 reset_n;
    logic                 cpu_cyc;
    logic                 cpu_stb;
    logic                 cpu_we;
    cache_bus_pkg::addr_t cpu_adr;
    cache_bus_pkg::sel_t  cpu_sel;
    cache_bus_pkg::word_t cpu_dat_w;
    cache_bus_pkg::word_t cpu_dat_r;
    logic                 cpu_ack;
    logic                 mem_cyc;
    logic                 mem_stb;
    cache_bus_pkg::addr_t mem_adr;
    cache_bus_pkg::word_t mem_dat_r = '0;
    logic                 mem_ack = 1'b0;

    int                   mem_reads = 0;
    cache_bus_pkg::addr_t read_log[$];
    int                   delay_left = 0;
    logic                 mem_busy = 1'b0;
    int                   cycle_count = 0;

    always #5 clk = ~clk;

    cache_top #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_cache_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_sel   (cpu_sel),
        .cpu_dat_w (cpu_dat_w),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_adr   (mem_adr),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    function automatic cache_bus_pkg::word_t model_word(input cache_bus_pkg::addr_t adr);
        return adr ^ model_xor;
    endfunction

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "run stopped at the first error");
    endtask

    ////////////////////
    // memory model
    ////////////////////

    // each request waits 0 to 3 falling edges, ack lasts one cycle
    always @(negedge clk) begin
        mem_ack <= 1'b0;
        // reads only, so cyc and stb always move together
        if (mem_cyc !== mem_stb) begin
            $display("memory bus: mem_cyc and mem_stb differ at %0t", $time);
            stop_with_failure();
        end
        if (mem_cyc && mem_stb) begin
            if (!mem_busy) begin
                mem_busy   = 1'b1;
                delay_left = $urandom_range(max_ack_delay, 0);
            end
            if (delay_left == 0) begin
                mem_ack   <= 1'b1;
                mem_dat_r <= model_word(mem_adr);
                read_log.push_back(mem_adr);
                mem_reads  = mem_reads + 1;
                mem_busy   = 1'b0;
            end else begin
                delay_left = delay_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: no progress after %0d cycles", cycle_count);
            stop_with_failure();
        end
    end

    task automatic check_word(input string name, input cache_bus_pkg::word_t actual,
                              input cache_bus_pkg::word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_adr(input string name, input cache_bus_pkg::addr_t actual,
                             input cache_bus_pkg::addr_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset_n = 1'b1;
    endtask

    `include "cache_tb_tests.svh"

    initial begin
        reset_n   = 1'b0;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_sel   = '0;
        cpu_dat_w = '0;
        void'($urandom(rand_seed));
        apply_reset();
        run_directed_tests();
        $display("Regression passed");
        $finish;
    end

endmodule
